//--- logic/fec_pkg.sv
package fec_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Code geometry.
    // ~~~~~~~~~~~~~~~~~~~~
    localparam int SYM_SIZE  = 4;                // Bits per symbol, GF(2^4).
    localparam int RS_K      = 4;                // Data symbols per codeword.
    localparam int RS_N      = 6;                // Codeword length.
    localparam int RS_2T     = RS_N - RS_K;      // Parity symbols.
    localparam int NUM_H     = 8;                // Number of erasure patterns.
    localparam int ERR_LOC_W = $clog2(NUM_H);    // Pattern index width.
    localparam int CNT_W     = $clog2(RS_N + 1); // Wide enough to hold 0..RS_N.

    typedef logic [SYM_SIZE-1:0]              sym_t;
    typedef logic [RS_K-1:0][SYM_SIZE-1:0]    data_cw_t;
    typedef logic [RS_N-1:0][SYM_SIZE-1:0]    full_cw_t;
    typedef logic [RS_2T-1:0][SYM_SIZE-1:0]   par_cw_t;
    typedef logic [ERR_LOC_W-1:0]             err_loc_t;
    typedef logic [RS_N-1:0]                  erase_vec_t;

    // Field polynomial x^4+x+1, the x^4 term is implied.
    localparam sym_t RS_POLY = 4'h3;

    // g(x) = (x+a)(x+a^2) = x^2 + RS_G1*x + RS_G0.
    localparam sym_t RS_G1 = 4'h6;
    localparam sym_t RS_G0 = 4'h8;

    // Bit i set means symbol i is dropped.
    localparam erase_vec_t RS_ERR_LOC_LUT [NUM_H] = '{
        6'b000000,  // No erasures.
        6'b000001,  // Symbol 0.
        6'b100000,  // Symbol 5.
        6'b000110,  // Symbols 1 and 2.
        6'b100001,  // Symbols 0 and 5.
        6'b001000,  // Symbol 3.
        6'b010100,  // Symbols 2 and 4.
        6'b110000   // Symbols 4 and 5.
    };

    // Shift-and-add multiply, reducing by the field polynomial each step.
    function automatic sym_t gf_mul(sym_t a, sym_t b);
        sym_t acc;
        sym_t x;
        acc = '0;
        x   = a;
        for (int i = 0; i < SYM_SIZE; i++) begin
            if (b[i]) acc = acc ^ x;
            x = x[SYM_SIZE-1] ? sym_t'((x << 1) ^ RS_POLY) : sym_t'(x << 1);
        end
        return acc;
    endfunction

    typedef enum logic {
        IDLE,  // Waiting for a codeword.
        SEND   // Shifting symbols out.
    } stream_state_e;

endpackage

//--- logic/fec_cw_if.sv
`timescale 1ns/1ps

interface fec_cw_if;

    fec_pkg::full_cw_t cw;       // Symbol 0 in the low bits.
    fec_pkg::err_loc_t err_loc;  // Pattern index travelling with the beat.
    logic              valid;
    logic              ready;

    // ~~~~~~~~~~~~~~~~~~~~
    // Producer side.
    // ~~~~~~~~~~~~~~~~~~~~
    modport src (
        output cw,
        output err_loc,
        output valid,
        input  ready
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Consumer side.
    // ~~~~~~~~~~~~~~~~~~~~
    modport snk (
        input  cw,
        input  err_loc,
        input  valid,
        output ready
    );

endinterface

//--- logic/fec_rs_encoder.sv
`timescale 1ns/1ps

module fec_rs_encoder (
    input  logic               clk,
    input  logic               reset,
    input  fec_pkg::data_cw_t  data_in,
    input  fec_pkg::err_loc_t  err_loc_in,
    input  logic               data_in_valid,
    output logic               data_in_ready,
    fec_cw_if.src              out
);

    fec_pkg::par_cw_t parity;  // Index 0 is the x^1 term, goes to symbol 4.
    fec_pkg::sym_t    fb;      // LFSR feedback.

    assign data_in_ready = out.ready;  // Stall passes straight upstream.

    // ~~~~~~~~~~~~~~~~~~~~
    // Parity LFSR, unrolled.
    // ~~~~~~~~~~~~~~~~~~~~
    // Data symbol 0 is the highest power, so it enters first.
    always_comb begin
        parity = '0;
        fb     = '0;
        for (int i = 0; i < fec_pkg::RS_K; i++) begin
            fb        = data_in[i] ^ parity[0];
            parity[0] = parity[1] ^ fec_pkg::gf_mul(fb, fec_pkg::RS_G1);
            parity[1] = fec_pkg::gf_mul(fb, fec_pkg::RS_G0);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out.valid <= 1'b0;
        end else if (out.ready) begin
            out.valid <= data_in_valid;
        end
    end

    // Payload only moves when downstream can take it.
    always_ff @(posedge clk) begin
        if (out.ready) begin
            out.cw      <= {parity, data_in};  // Parity lands in symbols 4 and 5.
            out.err_loc <= err_loc_in;
        end
    end

endmodule

//--- logic/fec_err_inject.sv
`timescale 1ns/1ps

module fec_err_inject (
    input  logic  clk,
    input  logic  reset,
    fec_cw_if.snk in,
    fec_cw_if.src out
);

    // Stage 1 registers.
    fec_pkg::full_cw_t   s1_cw;
    fec_pkg::err_loc_t   s1_loc;
    fec_pkg::erase_vec_t s1_erase;
    logic                s1_valid;

    // Stage 2 registers.
    fec_pkg::full_cw_t                                 s2_cw;
    fec_pkg::err_loc_t                                 s2_loc;
    logic [fec_pkg::RS_N-1:0][fec_pkg::CNT_W-1:0]      s2_idx;
    logic [fec_pkg::CNT_W-1:0]                         s2_count;
    logic                                              s2_valid;

    // Combinational helpers.
    logic [fec_pkg::RS_N-1:0][fec_pkg::CNT_W-1:0]      idx_c;
    logic [fec_pkg::CNT_W-1:0]                         count_c;
    fec_pkg::full_cw_t                                 packed_c;

    assign in.ready = out.ready;  // Whole pipe freezes together.

    // ~~~~~~~~~~~~~~~~~~~~
    // Survivor indexing.
    // ~~~~~~~~~~~~~~~~~~~~
    // Erased symbols all park in the top slot, cleared in stage 3.
    always_comb begin
        count_c = '0;
        for (int i = 0; i < fec_pkg::RS_N; i++) begin
            if (!s1_erase[i]) begin
                idx_c[i] = count_c;
                count_c  = count_c + 1'b1;
            end else begin
                idx_c[i] = fec_pkg::CNT_W'(fec_pkg::RS_N - 1);
            end
        end
    end

    // Scatter, then blank everything at or above the survivor count.
    always_comb begin
        packed_c = '0;
        for (int j = 0; j < fec_pkg::RS_N; j++) begin
            packed_c[s2_idx[j]] = s2_cw[j];
        end
        for (int j = 0; j < fec_pkg::RS_N; j++) begin
            if (j >= s2_count) packed_c[j] = '0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Pipeline registers.
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            out.valid <= 1'b0;
        end else if (out.ready) begin
            s1_valid  <= in.valid;
            s2_valid  <= s1_valid;
            out.valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (out.ready) begin
            s1_cw       <= in.cw;                                 // Stage 1.
            s1_loc      <= in.err_loc;
            s1_erase    <= fec_pkg::RS_ERR_LOC_LUT[in.err_loc];
            s2_cw       <= s1_cw;                                 // Stage 2.
            s2_loc      <= s1_loc;
            s2_idx      <= idx_c;
            s2_count    <= count_c;
            out.cw      <= packed_c;                              // Stage 3.
            out.err_loc <= s2_loc;
        end
    end

endmodule

//--- logic/fec_sym_streamer.sv
`timescale 1ns/1ps

module fec_sym_streamer (
    input  logic              clk,
    input  logic              reset,
    fec_cw_if.snk             in,
    output fec_pkg::sym_t     sym_out,
    output logic              sym_valid,
    output logic              sym_last,
    input  logic              sym_ready,
    output fec_pkg::err_loc_t err_loc_out
);

    fec_pkg::stream_state_e    state_q;
    fec_pkg::full_cw_t         shift_q;   // Next symbol always sits in slot 0.
    logic [fec_pkg::CNT_W-1:0] left_q;    // Symbols still to send, including current.
    fec_pkg::erase_vec_t       in_erase;
    logic [fec_pkg::CNT_W-1:0] in_keep;
    logic                      accept;
    logic                      sym_fire;

    // Count survivors again from the carried pattern index.
    assign in_erase = fec_pkg::RS_ERR_LOC_LUT[in.err_loc];
    assign in_keep  = fec_pkg::CNT_W'(fec_pkg::RS_N - $countones(in_erase));

    assign in.ready = (state_q == fec_pkg::IDLE);  // Take a new codeword only when idle.
    assign accept   = in.valid && in.ready;

    // Outputs come straight from registers, so they hold during a stall.
    assign sym_out   = shift_q[0];
    assign sym_valid = (state_q == fec_pkg::SEND);
    assign sym_last  = sym_valid && (left_q == fec_pkg::CNT_W'(1));
    assign sym_fire  = sym_valid && sym_ready;

    // ~~~~~~~~~~~~~~~~~~~~
    // State.
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= fec_pkg::IDLE;
        end else begin
            case (state_q)
                fec_pkg::IDLE: begin
                    if (accept) state_q <= fec_pkg::SEND;
                end
                fec_pkg::SEND: begin
                    if (sym_fire && sym_last) state_q <= fec_pkg::IDLE;  // Final symbol gone.
                end
                default: state_q <= fec_pkg::IDLE;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Shift register.
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (accept) begin
            shift_q     <= in.cw;
            left_q      <= in_keep;
            err_loc_out <= in.err_loc;  // Held for the whole codeword.
        end else if (sym_fire) begin
            shift_q <= {fec_pkg::sym_t'(0), shift_q[fec_pkg::RS_N-1:1]};
            left_q  <= left_q - 1'b1;
        end
    end

endmodule

//--- logic/fec_top.sv
`timescale 1ns/1ps

module fec_top (
    input  logic              clk,
    input  logic              reset,
    input  fec_pkg::data_cw_t data_in,
    input  fec_pkg::err_loc_t err_loc_in,
    input  logic              data_in_valid,
    output logic              data_in_ready,
    output fec_pkg::sym_t     sym_out,
    output logic              sym_valid,
    output logic              sym_last,
    input  logic              sym_ready,
    output fec_pkg::err_loc_t err_loc_out
);

    // ~~~~~~~~~~~~~~~~~~~~
    // Codeword buses.
    // ~~~~~~~~~~~~~~~~~~~~
    fec_cw_if cw_enc ();  // Encoder to injector.
    fec_cw_if cw_inj ();  // Injector to streamer.

    fec_rs_encoder u_encoder (
        .clk           (clk),
        .reset         (reset),
        .data_in       (data_in),
        .err_loc_in    (err_loc_in),
        .data_in_valid (data_in_valid),
        .data_in_ready (data_in_ready),
        .out           (cw_enc)
    );

    fec_err_inject u_inject (
        .clk   (clk),
        .reset (reset),
        .in    (cw_enc),
        .out   (cw_inj)
    );

    fec_sym_streamer u_stream (
        .clk         (clk),
        .reset       (reset),
        .in          (cw_inj),
        .sym_out     (sym_out),
        .sym_valid   (sym_valid),
        .sym_last    (sym_last),
        .sym_ready   (sym_ready),
        .err_loc_out (err_loc_out)
    );

endmodule

//--- dv/fec_props.sv
`timescale 1ns/1ps

module fec_props (
    input logic          clk,
    input logic          reset,
    input fec_pkg::sym_t sym_out,
    input logic          sym_valid,
    input logic          sym_last,
    input logic          sym_ready,
    input logic          in_ready
);

    // ~~~~~~~~~~~~~~~~~~~~
    // Output stream.
    // ~~~~~~~~~~~~~~~~~~~~
    // A stalled symbol stays put until taken.
    assert property (@(posedge clk) disable iff (reset)
        sym_valid && !sym_ready |=> sym_valid && $stable(sym_out) && $stable(sym_last))
        else $error("sym_out or sym_last changed while stalled");

    // The stream only ends once the marked last symbol is taken.
    assert property (@(posedge clk) disable iff (reset)
        sym_valid && !(sym_ready && sym_last) |=> sym_valid)
        else $error("sym_valid dropped before sym_last was taken");

    // No new codeword until the final symbol of the current one has gone.
    assert property (@(posedge clk) disable iff (reset)
        $rose(in_ready) |-> $past(sym_valid && sym_ready && sym_last))
        else $error("input ready rose before the final symbol was taken");

endmodule

bind fec_sym_streamer fec_props u_props (
    .clk       (clk),
    .reset     (reset),
    .sym_out   (sym_out),
    .sym_valid (sym_valid),
    .sym_last  (sym_last),
    .sym_ready (sym_ready),
    .in_ready  (in.ready)
);

//--- dv/tb_fec_top.sv
`timescale 1ns/1ps

module tb_fec_top;

    localparam int NUM_ROWS   = 24;
    localparam int WAIT_LIMIT = 200;
    localparam int DONE_LIMIT = 4000;

    // Bit i set means symbol i is erased, one entry per pattern.
    localparam logic [5:0] ERASE_MASK [8] = '{
        6'b000000, 6'b000001, 6'b100000, 6'b000110,
        6'b100001, 6'b001000, 6'b010100, 6'b110000
    };

    logic              clk = 1'b0;
    logic              reset;
    fec_pkg::data_cw_t data_in;
    fec_pkg::err_loc_t err_loc_in;
    logic              data_in_valid;
    logic              data_in_ready;
    fec_pkg::sym_t     sym_out;
    logic              sym_valid;
    logic              sym_last;
    logic              sym_ready;
    fec_pkg::err_loc_t err_loc_out;

    fec_pkg::data_cw_t tbl_data  [NUM_ROWS];
    fec_pkg::err_loc_t tbl_loc   [NUM_ROWS];
    logic              tbl_stall [NUM_ROWS];  // Bubble before the row.
    fec_pkg::sym_t     exp_sym_q  [$];
    fec_pkg::err_loc_t exp_loc_q  [$];
    logic              exp_last_q [$];

    int          errors = 0;
    int          checks = 0;
    int          cw_done = 0;
    int          cw_syms = 0;
    int          cw_err_base = 0;
    logic        timed_out = 1'b0;
    logic        random_ready = 1'b0;
    logic [31:0] rng_ready = 32'h75f0;

    always #2 clk = ~clk;

    fec_top u_fec_top (
        .clk           (clk),
        .reset         (reset),
        .data_in       (data_in),
        .err_loc_in    (err_loc_in),
        .data_in_valid (data_in_valid),
        .data_in_ready (data_in_ready),
        .sym_out       (sym_out),
        .sym_valid     (sym_valid),
        .sym_last      (sym_last),
        .sym_ready     (sym_ready),
        .err_loc_out   (err_loc_out)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Compare tasks.
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic check_sym(input fec_pkg::sym_t got, input fec_pkg::sym_t want,
                             input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_loc(input fec_pkg::err_loc_t got, input fec_pkg::err_loc_t want,
                             input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic check_flag(input logic got, input logic want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    // Long division of d(x)*x^2 by (x+a)(x+a^2), then the survivors in order.
    task automatic push_expected(input fec_pkg::data_cw_t d, input fec_pkg::err_loc_t loc);
        fec_pkg::sym_t rem [6];  // Index is the power of x.
        fec_pkg::sym_t cw  [6];
        fec_pkg::sym_t q;
        fec_pkg::sym_t g1;
        fec_pkg::sym_t g0;
        int            last_idx;
        g1 = 4'h2 ^ fec_pkg::gf_mul(4'h2, 4'h2);                 // a + a^2.
        g0 = fec_pkg::gf_mul(4'h2, fec_pkg::gf_mul(4'h2, 4'h2));  // a * a^2.
        for (int i = 0; i < 6; i++) rem[i] = (i >= 2) ? d[5-i] : '0;
        for (int p = 5; p >= 2; p--) begin
            q        = rem[p];
            rem[p]   = '0;
            rem[p-1] = rem[p-1] ^ fec_pkg::gf_mul(q, g1);
            rem[p-2] = rem[p-2] ^ fec_pkg::gf_mul(q, g0);
        end
        for (int i = 0; i < 4; i++) cw[i] = d[i];
        cw[4]    = rem[1];
        cw[5]    = rem[0];
        last_idx = 0;
        for (int i = 0; i < 6; i++) begin
            if (!ERASE_MASK[loc][i]) last_idx = i;
        end
        for (int i = 0; i < 6; i++) begin
            if (!ERASE_MASK[loc][i]) begin
                exp_sym_q.push_back(cw[i]);
                exp_loc_q.push_back(loc);
                exp_last_q.push_back(i == last_idx);
            end
        end
    endtask

    // Random back-pressure on the symbol side.
    always @(posedge clk) begin
        if (random_ready) begin
            rng_ready = xorshift(rng_ready);
            sym_ready <= (rng_ready[1:0] != 2'b00);  // Low about one beat in four.
        end else begin
            sym_ready <= 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Stream collector.
    // ~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin : collect
        fec_pkg::err_loc_t want_loc;
        logic              want_last;
        if (!reset && sym_valid && data_in_ready) begin
            errors++;
            $display("CHECK FAILED at %0t ns: data_in_ready high while streaming", $time);
        end
        if (!reset && sym_valid && sym_ready) begin
            if (exp_sym_q.size() == 0) begin
                errors++;
                $display("Extra symbol %h came out after all expected codewords", sym_out);
            end else begin
                want_loc  = exp_loc_q.pop_front();
                want_last = exp_last_q.pop_front();
                check_sym(sym_out, exp_sym_q.pop_front(), "sym_out");
                check_loc(err_loc_out, want_loc, "err_loc_out");
                check_flag(sym_last, want_last, "sym_last");
                cw_syms++;
                if (want_last) begin
                    $display("Codeword %0d: err_loc %0d, %0d symbols, %s", cw_done, want_loc,
                             cw_syms, (errors == cw_err_base) ? "ok" : "mismatch");
                    cw_done++;
                    cw_syms     = 0;
                    cw_err_base = errors;
                end
            end
        end
    end

    initial begin : main
        logic [31:0] rng;
        int          waited;
        reset         = 1'b1;
        data_in       = '0;
        err_loc_in    = '0;
        data_in_valid = 1'b0;
        sym_ready     = 1'b1;
        rng           = 32'h75f0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            rng          = xorshift(rng);
            tbl_data[r]  = rng[15:0];
            tbl_loc[r]   = fec_pkg::err_loc_t'(r % 8);  // All eight patterns, three times.
            rng          = xorshift(rng);
            tbl_stall[r] = (r >= 8) && rng[0];          // First rows go back to back.
            push_expected(tbl_data[r], tbl_loc[r]);
        end
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag(sym_valid, 1'b0, "sym_valid after reset");
        check_flag(sym_last, 1'b0, "sym_last after reset");
        @(posedge clk);
        for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
            if (r == 8) random_ready <= 1'b1;
            if (tbl_stall[r]) begin
                data_in_valid <= 1'b0;
                @(posedge clk);
            end
            data_in       <= tbl_data[r];
            err_loc_in    <= tbl_loc[r];
            data_in_valid <= 1'b1;
            waited = 0;
            @(negedge clk);
            while (!data_in_ready && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (!data_in_ready) begin
                $display("Timeout: data_in_ready stayed low for %0d cycles at row %0d",
                         WAIT_LIMIT, r);
                timed_out = 1'b1;
            end
            @(posedge clk);
        end
        data_in_valid <= 1'b0;
        waited = 0;
        while (cw_done < NUM_ROWS && !timed_out && waited < DONE_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (cw_done < NUM_ROWS && !timed_out) begin
            $display("Timeout: only %0d of %0d codewords came out", cw_done, NUM_ROWS);
            timed_out = 1'b1;
        end
        repeat (20) @(negedge clk);  // Room for stray symbols.
        $display("Codewords %0d of %0d, checks %0d, errors %0d, symbols missing %0d",
                 cw_done, NUM_ROWS, checks, errors, exp_sym_q.size());
        if (errors == 0 && !timed_out && exp_sym_q.size() == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- tb.f
logic/fec_pkg.sv
logic/fec_cw_if.sv
logic/fec_rs_encoder.sv
logic/fec_err_inject.sv
logic/fec_sym_streamer.sv
logic/fec_top.sv
dv/fec_props.sv
dv/tb_fec_top.sv

//--- Bender.yml
package:
  name: fec_erasure

sources:
  - logic/fec_pkg.sv
  - logic/fec_cw_if.sv
  - logic/fec_rs_encoder.sv
  - logic/fec_err_inject.sv
  - logic/fec_sym_streamer.sv
  - logic/fec_top.sv
  - target: simulation
    files:
      - dv/fec_props.sv
      - dv/tb_fec_top.sv
